/* Bender.yml */
package:
  name: c64_loader

export_include_dirs:
  - include

sources:
  - logic/loader_pkg.sv
  - logic/prg_loader.sv
  - logic/crt_loader.sv
  - logic/mem_write_master.sv
  - logic/c64_loader_top.sv
  - target: test
    files:
      - dv/tb_loader.sv

/* dv/loader_tests.txt */
# Columns are an op letter then hex fields: S idx off bytes.. | F idx off count | E
# W addr bytes.. | B type num laddr size | C id exrom game | M min_busy_cycles
# PRG file loaded at 0801, twelve program bytes
S 4 0 01 08 0a 08 0a 00 99 22 48 49 22 00 00 00
E
W 801 0a 08 0a 00 99 22 48 49 22 00 00 00
# BASIC pointers, start 0801 and end 080d
W 2b 01 08 0d 08 0d 08 0d 08
W ac 01 08 0d 08
M 100
# CRT file header with id 1234, EXROM 00, GAME 01
F 5 0 16
S 5 16 12 34 00 01
F 5 1a 26
# Two chip packets, the second one starts a new 8 KB block
S 5 40 43 48 49 50 00 00 00 14 00 00 00 00 80 00 20 00
S 5 50 a1 a2 a3 a4
S 5 54 43 48 49 50 00 00 00 13 00 01 00 01 a0 00 20 00
S 5 64 b1 b2 b3
E
W 100000 a1 a2 a3 a4
W 102000 b1 b2 b3
B 00 0000 8000 2000
B 01 0001 a000 2000
C 1234 00 01

/* dv/tb_loader.sv */
//================================================
// Loader testbench
// Test file driven download stream, AXI4-Lite
// slave with random ready delays, write and bank
// descriptor checks
//================================================
`include "loader_config.svh"

module tb_loader;
	timeunit 1ns;
	timeprecision 100ps;

	logic                      clk_sys     = 1'b0;
	logic                      reset_n     = 1'b0;
	logic                      dl_active_i = 1'b0;
	logic [7:0]                dl_index_i  = 8'h00;
	logic [`LOADER_ADDR_W-1:0] dl_offset_i = '0;
	logic [7:0]                dl_data_i   = 8'h00;
	logic                      dl_wr_i     = 1'b0;
	logic                      m_awready_i = 1'b0;
	logic                      m_wready_i  = 1'b0;
	logic                      m_bvalid_i  = 1'b0;
	logic [1:0]                m_bresp_i   = 2'b00;

	logic                      dl_wait_o, busy_o, m_awvalid_o, m_wvalid_o;
	logic                      m_wstrb_o, m_bready_o, cart_attached_o, bank_valid_o;
	logic [`LOADER_ADDR_W-1:0] m_awaddr_o;
	logic [7:0]                m_wdata_o, cart_exrom_o, cart_game_o, bank_type_o;
	logic [15:0]               cart_id_o, bank_num_o, bank_laddr_o, bank_size_o;

	integer      seed = 32'hf522_9e3a;
	logic [1:0]  aw_cnt = 2'd0;
	logic [1:0]  w_cnt = 2'd0;
	logic        aw_seen = 1'b0;
	logic        w_seen = 1'b0;
	logic        bank_valid_d = 1'b0;
	logic [`LOADER_ADDR_W-1:0] aw_addr = '0;
	logic [7:0]  w_data = 8'h00;
	int          busy_cycles = 0;
	int          busy_mark = 0;
	longint      limit_ns = 0;
	logic [32:0] got_q[$];
	logic [55:0] bank_q[$];
	string       lines[$];
	string       toks[$];

	c64_loader_top dut (.*);

	initial begin
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// Breaks a line into whitespace separated tokens
	task automatic split_tokens(input string s);
		int   i;
		int   start;
		byte  c;
		logic sep;
		toks.delete();
		start = -1;
		for (i = 0; i <= s.len(); i++) begin
			c   = (i < s.len()) ? s.getc(i) : 8'h20;
			sep = (c == 8'h20) || (c == 8'h09) || (c == 8'h0a) || (c == 8'h0d);
			if (sep && (start >= 0)) begin
				toks.push_back(s.substr(start, i - 1));
				start = -1;
			end else if (!sep && (start < 0)) begin
				start = i;
			end
		end
	endtask

	function automatic logic [31:0] token_value(input int k);
		return toks[k].atohex();
	endfunction

	task automatic start_download(input logic [7:0] idx);
		@(posedge clk_sys);
		dl_index_i  <= idx;
		dl_active_i <= 1'b1;
	endtask

	// Offer one byte once the loader no longer stalls the stream
	task automatic send_byte(input logic [7:0] idx, input logic [`LOADER_ADDR_W-1:0] off,
			input logic [7:0] data);
		@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		dl_index_i  <= idx;
		dl_offset_i <= off;
		dl_data_i   <= data;
		dl_wr_i     <= 1'b1;
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
	endtask

	// Drop the active flag, then wait for the walk and all writes to drain
	task automatic end_download();
		@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
		busy_mark = busy_cycles;
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (3) @(negedge clk_sys);
		while (busy_o || dl_wait_o || m_awvalid_o || m_wvalid_o || m_bvalid_i)
			@(negedge clk_sys);
	endtask

	task automatic expect_write(input logic [`LOADER_ADDR_W-1:0] addr, input logic [7:0] data);
		logic [32:0] entry;
		if (got_q.size() == 0) begin
			$display("Missing write: nothing completed for address %0h", addr);
			abort_run();
		end
		entry = got_q.pop_front();
		check_value(entry[32:8], addr, "write address");
		check_value(entry[7:0], data, "write data");
	endtask

	task automatic expect_bank(input logic [55:0] exp);
		if (bank_q.size() == 0) begin
			$display("Missing bank descriptor: no bank_valid_o pulse was seen");
			abort_run();
		end
		check_value(bank_q.pop_front(), exp, "bank type, number, load address and size");
	endtask

	//================================================
	// AXI4-Lite slave with random ready delays
	//================================================
	always @(posedge clk_sys) begin
		if (!reset_n) begin
			m_awready_i <= 1'b0;
			m_wready_i  <= 1'b0;
			m_bvalid_i  <= 1'b0;
			aw_seen     <= 1'b0;
			w_seen      <= 1'b0;
		end else begin
			m_bvalid_i <= 1'b0;
			if (m_bvalid_i)
				check_value(m_bready_o, 1, "BREADY during the write response");
			if (m_awvalid_o && m_awready_i) begin
				m_awready_i <= 1'b0;
				aw_addr     <= m_awaddr_o;
				aw_seen     <= 1'b1;
				aw_cnt      <= 2'($random(seed));
			end else if (m_awvalid_o && !aw_seen) begin
				if (aw_cnt == 2'd0)
					m_awready_i <= 1'b1;
				else
					aw_cnt <= aw_cnt - 1'b1;
			end
			if (m_wvalid_o && m_wready_i) begin
				check_value(m_wstrb_o, 1, "WSTRB of the single byte lane");
				m_wready_i <= 1'b0;
				w_data     <= m_wdata_o;
				w_seen     <= 1'b1;
				w_cnt      <= 2'($random(seed));
			end else if (m_wvalid_o && !w_seen) begin
				if (w_cnt == 2'd0)
					m_wready_i <= 1'b1;
				else
					w_cnt <= w_cnt - 1'b1;
			end
			// Respond once both halves of the write have arrived
			if (aw_seen && w_seen && !m_bvalid_i) begin
				m_bvalid_i <= 1'b1;
				aw_seen    <= 1'b0;
				w_seen     <= 1'b0;
				got_q.push_back({aw_addr, w_data});
			end
		end
	end

	always @(posedge clk_sys) begin
		if (busy_o)
			busy_cycles <= busy_cycles + 1;
		if (reset_n && bank_valid_o)
			bank_q.push_back({bank_type_o, bank_num_o, bank_laddr_o, bank_size_o});
		bank_valid_d <= bank_valid_o;
	end

	always @(negedge clk_sys) begin
		if (reset_n && dl_wr_i && dl_wait_o) begin
			$display("Protocol failure: a byte was offered while dl_wait_o was high");
			abort_run();
		end else if (reset_n && bank_valid_o && bank_valid_d) begin
			$display("Protocol failure: bank_valid_o stayed high for more than one cycle");
			abort_run();
		end
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		abort_run();
	end

	//================================================
	// Test file sequencer
	//================================================
	initial begin
		int    fd;
		int    n;
		int    k;
		int    count;
		string line;
		byte   op;
		logic [7:0] idx;
		logic [`LOADER_ADDR_W-1:0] base;

		fd = $fopen("dv/loader_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test file dv/loader_tests.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) > 0)
				lines.push_back(line);
		end
		$fclose(fd);
		// Roughly a thousand cycles per test line
		limit_ns = 64'(lines.size()) * 4000;

		repeat (3) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(negedge clk_sys);
		check_value({m_awvalid_o, m_wvalid_o, dl_wait_o, busy_o, bank_valid_o,
			cart_attached_o}, 0, "outputs after reset");

		for (n = 0; n < lines.size(); n++) begin
			split_tokens(lines[n]);
			if (toks.size() == 0)
				continue;
			op = toks[0].getc(0);
			case (op)
				"#": ;
				"S", "F": begin
					idx  = 8'(token_value(1));
					base = `LOADER_ADDR_W'(token_value(2));
					if (!dl_active_i)
						start_download(idx);
					if (op == "S") begin
						for (k = 3; k < toks.size(); k++)
							send_byte(idx, base + `LOADER_ADDR_W'(k - 3), 8'(token_value(k)));
					end else begin
						count = int'(token_value(3));
						for (k = 0; k < count; k++)
							send_byte(idx, base + `LOADER_ADDR_W'(k), 8'h00);
					end
				end
				"E": end_download();
				"W": begin
					base = `LOADER_ADDR_W'(token_value(1));
					for (k = 2; k < toks.size(); k++)
						expect_write(base + `LOADER_ADDR_W'(k - 2), 8'(token_value(k)));
				end
				"B": expect_bank({8'(token_value(1)), 16'(token_value(2)),
					16'(token_value(3)), 16'(token_value(4))});
				"C": begin
					check_value(cart_id_o, token_value(1), "cartridge id");
					check_value(cart_exrom_o, token_value(2), "EXROM");
					check_value(cart_game_o, token_value(3), "GAME");
					check_value(cart_attached_o, 1, "cartridge attached");
				end
				"M": begin
					check_value((busy_cycles - busy_mark) >= int'(token_value(1)), 1,
						"busy cycles covering the pointer walk");
					check_value(busy_o, 0, "busy after the pointer walk");
				end
				default: begin
					$display("Unknown command in test file line %0d", n + 1);
					abort_run();
				end
			endcase
		end

		check_value(got_q.size(), 0, "count of unmatched writes");
		check_value(bank_q.size(), 0, "count of unmatched bank descriptors");
		$display("Done: no errors");
		$finish;
	end

endmodule

/* include/loader_config.svh */
//================================================
// Loader configuration macros
// Address width, storage bases, host file indices
// and the zero-page pointer walk limit
//================================================
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// System memory address width
`define LOADER_ADDR_W 25

// Cartridge image storage starts here
`define LOADER_CRT_BASE 25'h100000

// Host file indices
`define LOADER_IDX_PRG 8'd4
`define LOADER_IDX_CRT 8'd5

// Chip packets land on 8 KB blocks
`define LOADER_CRT_BLOCK_W 13

// Pointer walk covers the zero page only
`define LOADER_MEMINIT_END 25'h100

`endif

/* logic/c64_loader_top.sv */
//================================================
// File loader top level
// PRG and CRT parsers sharing one write master
//================================================
`include "loader_config.svh"

module c64_loader_top (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      dl_active_i,
	input  logic [7:0]                dl_index_i,
	input  logic [`LOADER_ADDR_W-1:0] dl_offset_i,
	input  logic [7:0]                dl_data_i,
	input  logic                      dl_wr_i,
	input  logic                      m_awready_i,
	input  logic                      m_wready_i,
	input  logic                      m_bvalid_i,
	input  logic [1:0]                m_bresp_i,
	output logic                      dl_wait_o,
	output logic                      busy_o,
	output logic                      m_awvalid_o,
	output logic [`LOADER_ADDR_W-1:0] m_awaddr_o,
	output logic                      m_wvalid_o,
	output logic [7:0]                m_wdata_o,
	output logic                      m_wstrb_o,
	output logic                      m_bready_o,
	output logic [15:0]               cart_id_o,
	output logic [7:0]                cart_exrom_o,
	output logic [7:0]                cart_game_o,
	output logic                      cart_attached_o,
	output logic                      bank_valid_o,
	output logic [7:0]                bank_type_o,
	output logic [15:0]               bank_num_o,
	output logic [15:0]               bank_laddr_o,
	output logic [15:0]               bank_size_o
);

	logic                      prg_req;
	logic [`LOADER_ADDR_W-1:0] prg_addr;
	logic [7:0]                prg_data;
	logic                      prg_grant;

	logic                      crt_req;
	logic [`LOADER_ADDR_W-1:0] crt_addr;
	logic [7:0]                crt_data;
	logic                      crt_grant;

	prg_loader u_prg_loader (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_offset_i (dl_offset_i),
		.dl_data_i   (dl_data_i),
		.dl_wr_i     (dl_wr_i),
		.grant_i     (prg_grant),
		.req_o       (prg_req),
		.req_addr_o  (prg_addr),
		.req_data_o  (prg_data),
		.busy_o      (busy_o)
	);

	crt_loader u_crt_loader (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_offset_i     (dl_offset_i),
		.dl_data_i       (dl_data_i),
		.dl_wr_i         (dl_wr_i),
		.grant_i         (crt_grant),
		.req_o           (crt_req),
		.req_addr_o      (crt_addr),
		.req_data_o      (crt_data),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o),
		.bank_valid_o    (bank_valid_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o)
	);

	mem_write_master u_mem_write_master (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.prg_req_i   (prg_req),
		.prg_addr_i  (prg_addr),
		.prg_data_i  (prg_data),
		.crt_req_i   (crt_req),
		.crt_addr_i  (crt_addr),
		.crt_data_i  (crt_data),
		.awready_i   (m_awready_i),
		.wready_i    (m_wready_i),
		.bvalid_i    (m_bvalid_i),
		.bresp_i     (m_bresp_i),
		.prg_grant_o (prg_grant),
		.crt_grant_o (crt_grant),
		.dl_wait_o   (dl_wait_o),
		.awvalid_o   (m_awvalid_o),
		.awaddr_o    (m_awaddr_o),
		.wvalid_o    (m_wvalid_o),
		.wdata_o     (m_wdata_o),
		.wstrb_o     (m_wstrb_o),
		.bready_o    (m_bready_o)
	);

endmodule

/* logic/crt_loader.sv */
//================================================
// CRT file parser
// File header fields, chip packet headers with
// bank reporting and 8 KB aligned data writes
//================================================
`include "loader_config.svh"

module crt_loader import loader_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      dl_active_i,
	input  logic [7:0]                dl_index_i,
	input  logic [`LOADER_ADDR_W-1:0] dl_offset_i,
	input  logic [7:0]                dl_data_i,
	input  logic                      dl_wr_i,
	input  logic                      grant_i,
	output logic                      req_o,
	output logic [`LOADER_ADDR_W-1:0] req_addr_o,
	output logic [7:0]                req_data_o,
	output logic [15:0]               cart_id_o,
	output logic [7:0]                cart_exrom_o,
	output logic [7:0]                cart_game_o,
	output logic                      cart_attached_o,
	output logic                      bank_valid_o,
	output logic [7:0]                bank_type_o,
	output logic [15:0]               bank_num_o,
	output logic [15:0]               bank_laddr_o,
	output logic [15:0]               bank_size_o
);

	crt_state_e state;

	logic [`LOADER_ADDR_W-1:0] wr_addr;
	logic [31:0] blk_len;
	logic [3:0]  hdr_cnt;
	logic        active_d;

	logic is_crt;
	logic take;
	logic hdr_byte;
	logic hdr_last;
	logic data_byte;

	assign is_crt    = (dl_index_i == `LOADER_IDX_CRT);
	assign take      = dl_wr_i && is_crt;
	assign hdr_byte  = take && (state == CRT_PKT_HDR);
	assign hdr_last  = hdr_byte && (hdr_cnt == 4'd15);
	assign data_byte = take && (state == CRT_PKT_DATA);

	//================================================
	// Control
	//================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state           <= CRT_FILE_HDR;
			hdr_cnt         <= 4'd0;
			req_o           <= 1'b0;
			bank_valid_o    <= 1'b0;
			cart_attached_o <= 1'b0;
			active_d        <= 1'b0;
		end else begin
			active_d     <= dl_active_i;
			bank_valid_o <= hdr_last;

			if (grant_i)
				req_o <= 1'b0;
			if (data_byte)
				req_o <= 1'b1;

			// Attached once a full image has gone through
			if (is_crt && active_d && !dl_active_i)
				cart_attached_o <= 1'b1;
			else if (is_crt && !active_d && dl_active_i)
				cart_attached_o <= 1'b0;

			if (take) begin
				case (state)
					CRT_FILE_HDR: begin
						if (dl_offset_i == 'h3F) begin
							state   <= CRT_PKT_HDR;
							hdr_cnt <= 4'd0;
						end
					end
					CRT_PKT_HDR: begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt == 4'd15)
							state <= (blk_len == '0) ? CRT_PKT_HDR : CRT_PKT_DATA;
					end
					CRT_PKT_DATA: begin
						if (blk_len == 32'd1)
							state <= CRT_PKT_HDR;
					end
					default: state <= CRT_FILE_HDR;
				endcase

				// A new image restarts the parse
				if (dl_offset_i == 'd0) begin
					state   <= CRT_FILE_HDR;
					hdr_cnt <= 4'd0;
				end
			end
		end
	end

	//================================================
	// Header fields and write payload
	//================================================
	always_ff @(posedge clk_sys) begin
		if (take && (dl_offset_i == 'd0))
			wr_addr <= `LOADER_CRT_BASE;

		if (take && (state == CRT_FILE_HDR)) begin
			case (dl_offset_i)
				'h16:    cart_id_o[15:8] <= dl_data_i;
				'h17:    cart_id_o[7:0]  <= dl_data_i;
				'h18:    cart_exrom_o    <= dl_data_i;
				'h19:    cart_game_o     <= dl_data_i;
				default: ;
			endcase
		end

		if (hdr_byte) begin
			case (hdr_cnt)
				4'd0: begin
					// Round up to the next block boundary
					if (wr_addr[`LOADER_CRT_BLOCK_W-1:0] != '0) begin
						wr_addr[`LOADER_ADDR_W-1:`LOADER_CRT_BLOCK_W] <=
							wr_addr[`LOADER_ADDR_W-1:`LOADER_CRT_BLOCK_W] + 1'b1;
						wr_addr[`LOADER_CRT_BLOCK_W-1:0] <= '0;
					end
				end
				4'd4:  blk_len[31:24]     <= dl_data_i;
				4'd5:  blk_len[23:16]     <= dl_data_i;
				4'd6:  blk_len[15:8]      <= dl_data_i;
				4'd7:  blk_len[7:0]       <= dl_data_i;
				// Packet length includes its own 16 byte header
				4'd8:  blk_len            <= blk_len - 32'd16;
				4'd9:  bank_type_o        <= dl_data_i;
				4'd10: bank_num_o[15:8]   <= dl_data_i;
				4'd11: bank_num_o[7:0]    <= dl_data_i;
				4'd12: bank_laddr_o[15:8] <= dl_data_i;
				4'd13: bank_laddr_o[7:0]  <= dl_data_i;
				4'd14: bank_size_o[15:8]  <= dl_data_i;
				4'd15: bank_size_o[7:0]   <= dl_data_i;
				default: ;
			endcase
		end

		if (data_byte) begin
			req_addr_o <= wr_addr;
			req_data_o <= dl_data_i;
			wr_addr    <= wr_addr + 1'b1;
			blk_len    <= blk_len - 1'b1;
		end
	end

endmodule

/* logic/loader_pkg.sv */
//================================================
// Loader package
// FSM state encodings and the pointer-patch opcode
//================================================
package loader_pkg;

	// PRG loader FSM
	typedef enum logic [1:0] {
		PRG_IDLE,
		PRG_LOAD,
		PRG_MEMINIT
	} prg_state_e;

	// CRT loader FSM
	typedef enum logic [1:0] {
		CRT_FILE_HDR,
		CRT_PKT_HDR,
		CRT_PKT_DATA
	} crt_state_e;

	// Which byte goes into a BASIC pointer
	typedef enum logic [2:0] {
		PTR_NONE,
		PTR_START_LO,
		PTR_START_HI,
		PTR_END_LO,
		PTR_END_HI
	} ptr_sel_e;

	// Write master, one write in flight at most
	typedef enum logic {
		WR_IDLE,
		WR_ACTIVE
	} wr_state_e;

endpackage

/* logic/mem_write_master.sv */
//================================================
// Memory write master
// Request arbitration, download back-pressure and
// a single-outstanding AXI4-Lite write channel
//================================================
`include "loader_config.svh"

module mem_write_master import loader_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      prg_req_i,
	input  logic [`LOADER_ADDR_W-1:0] prg_addr_i,
	input  logic [7:0]                prg_data_i,
	input  logic                      crt_req_i,
	input  logic [`LOADER_ADDR_W-1:0] crt_addr_i,
	input  logic [7:0]                crt_data_i,
	input  logic                      awready_i,
	input  logic                      wready_i,
	input  logic                      bvalid_i,
	input  logic [1:0]                bresp_i,
	output logic                      prg_grant_o,
	output logic                      crt_grant_o,
	output logic                      dl_wait_o,
	output logic                      awvalid_o,
	output logic [`LOADER_ADDR_W-1:0] awaddr_o,
	output logic                      wvalid_o,
	output logic [7:0]                wdata_o,
	output logic                      wstrb_o,
	output logic                      bready_o
);

	wr_state_e wr_state;

	// PRG wins a tie
	assign prg_grant_o = (wr_state == WR_IDLE) && prg_req_i;
	assign crt_grant_o = (wr_state == WR_IDLE) && !prg_req_i && crt_req_i;

	// A pending request already stalls the stream before it is granted
	assign dl_wait_o = (wr_state != WR_IDLE) || prg_req_i || crt_req_i;

	assign wstrb_o  = 1'b1;
	assign bready_o = 1'b1;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_state  <= WR_IDLE;
			awvalid_o <= 1'b0;
			wvalid_o  <= 1'b0;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (prg_grant_o || crt_grant_o) begin
						wr_state  <= WR_ACTIVE;
						awvalid_o <= 1'b1;
						wvalid_o  <= 1'b1;
					end
				end
				WR_ACTIVE: begin
					// AW and W handshake on their own
					if (awvalid_o && awready_i)
						awvalid_o <= 1'b0;
					if (wvalid_o && wready_i)
						wvalid_o <= 1'b0;
					if (bvalid_i)
						wr_state <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// Holding register for the granted write
	always_ff @(posedge clk_sys) begin
		if (prg_grant_o) begin
			awaddr_o <= prg_addr_i;
			wdata_o  <= prg_data_i;
		end else if (crt_grant_o) begin
			awaddr_o <= crt_addr_i;
			wdata_o  <= crt_data_i;
		end
	end

	//================================================
	// Channel checks
	//================================================
	a_aw_stable: assert property (@(posedge clk_sys) disable iff (!reset_n)
		awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
		else $error("AWADDR changed while waiting for AWREADY");

	a_w_stable: assert property (@(posedge clk_sys) disable iff (!reset_n)
		wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
		else $error("WDATA changed while waiting for WREADY");

	// Response only after both handshakes of the one write in flight
	a_b_outstanding: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bvalid_i |-> (wr_state == WR_ACTIVE) && !awvalid_o && !wvalid_o
			&& (bresp_i == 2'b00))
		else $error("Unexpected or failed write response");

endmodule

/* logic/prg_loader.sv */
//================================================
// PRG file parser
// Load address capture, byte write requests and
// the BASIC pointer patch after the download
//================================================
`include "loader_config.svh"

module prg_loader import loader_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      dl_active_i,
	input  logic [7:0]                dl_index_i,
	input  logic [`LOADER_ADDR_W-1:0] dl_offset_i,
	input  logic [7:0]                dl_data_i,
	input  logic                      dl_wr_i,
	input  logic                      grant_i,
	output logic                      req_o,
	output logic [`LOADER_ADDR_W-1:0] req_addr_o,
	output logic [7:0]                req_data_o,
	output logic                      busy_o
);

	prg_state_e state;
	ptr_sel_e   ptr_sel;

	logic [`LOADER_ADDR_W-1:0] load_addr;
	logic [15:0] start_addr;
	logic [15:0] end_addr;
	logic [7:0]  ptr_data;

	logic is_prg;
	logic take;
	logic data_byte;
	logic walk_start;
	logic walk_idle;
	logic walk_done;
	logic walk_issue;

	assign is_prg     = (dl_index_i == `LOADER_IDX_PRG);
	assign take       = dl_wr_i && is_prg && (state != PRG_MEMINIT);
	// Offsets 0 and 1 carry the load address
	assign data_byte  = take && (dl_offset_i > 'd1);
	assign walk_start = (state == PRG_LOAD) && !dl_active_i;
	assign walk_idle  = (state == PRG_MEMINIT) && !req_o;
	assign walk_done  = walk_idle && (load_addr == `LOADER_MEMINIT_END);
	assign walk_issue = walk_idle && !walk_done && (ptr_sel != PTR_NONE);
	assign busy_o     = (state == PRG_MEMINIT);

	//================================================
	// Zero-page pointer decode
	//================================================
	always_comb begin
		case (load_addr[7:0])
			// TXT and SAVE_START
			8'h2B, 8'hAC:               ptr_sel = PTR_START_LO;
			8'h2C, 8'hAD:               ptr_sel = PTR_START_HI;
			// VAR, ARY, STR and LOAD_END
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_sel = PTR_END_LO;
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_sel = PTR_END_HI;
			default:                    ptr_sel = PTR_NONE;
		endcase
	end

	always_comb begin
		case (ptr_sel)
			PTR_START_LO: ptr_data = start_addr[7:0];
			PTR_START_HI: ptr_data = start_addr[15:8];
			PTR_END_LO:   ptr_data = end_addr[7:0];
			PTR_END_HI:   ptr_data = end_addr[15:8];
			default:      ptr_data = 8'h00;
		endcase
	end

	//================================================
	// Control
	//================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state <= PRG_IDLE;
			req_o <= 1'b0;
		end else begin
			if (grant_i)
				req_o <= 1'b0;
			if (data_byte || walk_issue)
				req_o <= 1'b1;

			case (state)
				PRG_IDLE: begin
					if (dl_active_i && is_prg)
						state <= PRG_LOAD;
				end
				PRG_LOAD: begin
					if (walk_start)
						state <= PRG_MEMINIT;
				end
				PRG_MEMINIT: begin
					if (walk_done)
						state <= PRG_IDLE;
				end
				default: state <= PRG_IDLE;
			endcase
		end
	end

	// Address, pointer values and write payload
	always_ff @(posedge clk_sys) begin
		if (take && (dl_offset_i == 'd0)) begin
			load_addr        <= {{(`LOADER_ADDR_W-8){1'b0}}, dl_data_i};
			start_addr[7:0]  <= dl_data_i;
			end_addr[7:0]    <= dl_data_i;
		end
		if (take && (dl_offset_i == 'd1)) begin
			load_addr[15:8]  <= dl_data_i;
			start_addr[15:8] <= dl_data_i;
			end_addr[15:8]   <= dl_data_i;
		end
		if (data_byte) begin
			req_addr_o <= load_addr;
			req_data_o <= dl_data_i;
			load_addr  <= load_addr + 1'b1;
			end_addr   <= end_addr + 1'b1;
		end

		if (walk_start)
			load_addr <= '0;
		// One zero-page address per cycle while no write is pending
		if (walk_idle && !walk_done) begin
			load_addr <= load_addr + 1'b1;
			if (walk_issue) begin
				req_addr_o <= load_addr;
				req_data_o <= ptr_data;
			end
		end
	end

	a_req_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		req_o && !grant_i |=> req_o && $stable(req_addr_o) && $stable(req_data_o))
		else $error("PRG request dropped or changed before grant");

endmodule

/* verilog.f */
+incdir+include
logic/loader_pkg.sv
logic/prg_loader.sv
logic/crt_loader.sv
logic/mem_write_master.sv
logic/c64_loader_top.sv
dv/tb_loader.sv
